// File: source/uart_loader_defines.svh
// uart loader constants
`ifndef UART_LOADER_DEFINES_SVH
`define UART_LOADER_DEFINES_SVH

// serial timing
`define BAUD_DIV 16         // clock cycles per bit

// memory size
`define RAM_AW 10           // 1024 words

// host command bytes
`define CMD_WRITE 8'h01
`define CMD_READ  8'h02
`define CMD_RUN   8'h03
`define CMD_HALT  8'h04

// reply bytes
`define RPL_ERR   8'hEE     // unknown command
`define RPL_FAULT 8'hFF     // cpu fault report

`endif

// File: source/uart_loader_pkg.sv
// uart loader types
`default_nettype none

`include "uart_loader_defines.svh"

package uart_loader_pkg;

typedef logic [7:0]         byte_t;
typedef logic [31:0]        word_t;
typedef logic [31:0]        addr_t;     // host byte address
typedef logic [`RAM_AW-1:0] ram_addr_t; // ram word address

typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
} rx_state_e;

typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_DATA, TX_STOP
} tx_state_e;

typedef enum logic [2:0] {
    LD_CMD, LD_ADDR, LD_DATA, LD_WRITE, LD_READ, LD_SEND, LD_FAULT
} loader_state_e;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
// uart serial receiver
`timescale 1ns/1ps
`default_nettype none

`include "uart_loader_defines.svh"

module uart_rx(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   data_i,
    input  logic                   init_i,
    output logic                   done_o,
    output uart_loader_pkg::byte_t data_o
);

localparam int CW = $clog2(`BAUD_DIV);

uart_loader_pkg::rx_state_e state_q;
uart_loader_pkg::byte_t     shift_q;

logic [2:0]    sync_q;
logic [CW-1:0] cnt_q;
logic [2:0]    bit_q;

logic line;
logic fall;
logic half_end;
logic bit_end;

assign line     = sync_q[1];
assign fall     = sync_q[2] & ~sync_q[1];           // start edge
assign half_end = (cnt_q == CW'(`BAUD_DIV / 2 - 1));
assign bit_end  = (cnt_q == CW'(`BAUD_DIV - 1));

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sync_q <= 3'b111;                           // idle line is high
    end else begin
        sync_q <= {sync_q[1:0], data_i};
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= uart_loader_pkg::RX_IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        done_o  <= 1'b0;
    end else begin
        if (init_i) begin
            done_o <= 1'b0;
        end
        case (state_q)
            uart_loader_pkg::RX_IDLE: begin
                if (fall) begin
                    state_q <= uart_loader_pkg::RX_START;
                    cnt_q   <= '0;
                end
            end
            uart_loader_pkg::RX_START: begin
                if (half_end) begin
                    cnt_q   <= '0;
                    bit_q   <= '0;
                    // a glitch shorter than half a bit is dropped
                    state_q <= line ? uart_loader_pkg::RX_IDLE : uart_loader_pkg::RX_DATA;
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            uart_loader_pkg::RX_DATA: begin
                if (bit_end) begin
                    cnt_q <= '0;
                    bit_q <= bit_q + 3'd1;
                    if (bit_q == 3'd7) begin
                        state_q <= uart_loader_pkg::RX_STOP;
                    end
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            uart_loader_pkg::RX_STOP: begin
                if (bit_end) begin
                    state_q <= uart_loader_pkg::RX_IDLE;
                    if (line) begin
                        done_o <= 1'b1;             // framing error drops the byte
                    end
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            default: state_q <= uart_loader_pkg::RX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state_q == uart_loader_pkg::RX_DATA && bit_end) begin
        shift_q <= {line, shift_q[7:1]};            // lsb first
    end
    if (state_q == uart_loader_pkg::RX_STOP && bit_end && line) begin
        data_o <= shift_q;
    end
end

a_done_no_rise_on_init: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(done_o) |-> !$past(init_i));

endmodule

`default_nettype wire

// File: source/uart_tx.sv
// uart serial transmitter
`timescale 1ns/1ps
`default_nettype none

`include "uart_loader_defines.svh"

module uart_tx(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic                   init_i,
    input  uart_loader_pkg::byte_t data_i,
    output logic                   done_o,
    output logic                   data_o
);

localparam int CW = $clog2(`BAUD_DIV);

uart_loader_pkg::tx_state_e state_q;
uart_loader_pkg::byte_t     shift_q;

logic [CW-1:0] cnt_q;
logic [2:0]    bit_q;
logic          line_q;
logic          bit_end;

assign bit_end = (cnt_q == CW'(`BAUD_DIV - 1));
assign done_o  = (state_q == uart_loader_pkg::TX_IDLE);
assign data_o  = line_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= uart_loader_pkg::TX_IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        line_q  <= 1'b1;
    end else begin
        case (state_q)
            uart_loader_pkg::TX_IDLE: begin
                line_q <= 1'b1;
                if (init_i) begin
                    state_q <= uart_loader_pkg::TX_START;
                    cnt_q   <= '0;
                    line_q  <= 1'b0;                // start bit
                end
            end
            uart_loader_pkg::TX_START: begin
                if (bit_end) begin
                    state_q <= uart_loader_pkg::TX_DATA;
                    cnt_q   <= '0;
                    bit_q   <= '0;
                    line_q  <= shift_q[0];
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            uart_loader_pkg::TX_DATA: begin
                if (bit_end) begin
                    cnt_q <= '0;
                    bit_q <= bit_q + 3'd1;
                    if (bit_q == 3'd7) begin
                        state_q <= uart_loader_pkg::TX_STOP;
                        line_q  <= 1'b1;
                    end else begin
                        line_q <= shift_q[1];       // next bit before the shift
                    end
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            uart_loader_pkg::TX_STOP: begin
                if (bit_end) begin
                    state_q <= uart_loader_pkg::TX_IDLE;
                end else begin
                    cnt_q <= cnt_q + CW'(1);
                end
            end
            default: state_q <= uart_loader_pkg::TX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (done_o && init_i) begin
        shift_q <= data_i;
    end else if (state_q == uart_loader_pkg::TX_DATA && bit_end) begin
        shift_q <= shift_q >> 1;
    end
end

a_init_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    init_i |-> done_o);

a_idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> data_o);

endmodule

`default_nettype wire

// File: source/ram_rw.sv
// host command processor
`timescale 1ns/1ps
`default_nettype none

`include "uart_loader_defines.svh"

module ram_rw(
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  uart_loader_pkg::byte_t     rx_data_i,
    input  logic                       rx_done_i,
    output logic                       rx_init_o,

    output uart_loader_pkg::byte_t     tx_data_o,
    output logic                       tx_init_o,
    input  logic                       tx_done_i,

    output uart_loader_pkg::ram_addr_t mem_addr_o,
    output uart_loader_pkg::word_t     mem_wdata_o,
    output logic                       mem_we_o,
    input  uart_loader_pkg::word_t     mem_rdata_i,

    input  logic                       cpu_fault_i,
    output logic                       cpu_rst_n_o
);

uart_loader_pkg::loader_state_e state_q;

uart_loader_pkg::byte_t cmd_q;
uart_loader_pkg::addr_t addr_q;
uart_loader_pkg::word_t wdata_q;
uart_loader_pkg::word_t rpl_q;              // reply bytes with the lsb sent first

logic [1:0] byte_cnt_q;
logic [2:0] rpl_cnt_q;
logic       run_q;
logic       fault_pend_q;
logic       rx_init_q;
logic       tx_init_q;
logic       take_ok;
logic       take;
logic       send;

always_comb begin
    case (state_q)
        uart_loader_pkg::LD_CMD:  take_ok = ~fault_pend_q;
        uart_loader_pkg::LD_ADDR: take_ok = 1'b1;
        uart_loader_pkg::LD_DATA: take_ok = 1'b1;
        default:                  take_ok = 1'b0;
    endcase
end

assign take = rx_done_i & ~rx_init_q & take_ok;     // done is still high during init
assign send = (state_q == uart_loader_pkg::LD_SEND) & tx_done_i & ~tx_init_q;

assign rx_init_o   = rx_init_q;
assign tx_init_o   = tx_init_q;
assign mem_addr_o  = addr_q[`RAM_AW+1:2];           // upper address bits ignored
assign mem_wdata_o = wdata_q;
assign mem_we_o    = (state_q == uart_loader_pkg::LD_WRITE);
assign cpu_rst_n_o = run_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q      <= uart_loader_pkg::LD_CMD;
        cmd_q        <= '0;
        addr_q       <= '0;
        wdata_q      <= '0;
        rpl_q        <= '0;
        tx_data_o    <= '0;
        byte_cnt_q   <= '0;
        rpl_cnt_q    <= '0;
        run_q        <= 1'b0;
        fault_pend_q <= 1'b0;
        rx_init_q    <= 1'b0;
        tx_init_q    <= 1'b0;
    end else begin
        rx_init_q <= take;
        tx_init_q <= send;
        case (state_q)
            uart_loader_pkg::LD_CMD: begin
                if (fault_pend_q) begin
                    state_q <= uart_loader_pkg::LD_FAULT;
                end else if (take) begin
                    cmd_q      <= rx_data_i;
                    byte_cnt_q <= '0;
                    rpl_cnt_q  <= 3'd1;
                    rpl_q      <= {24'd0, rx_data_i};   // echo
                    case (rx_data_i)
                        `CMD_WRITE, `CMD_READ: state_q <= uart_loader_pkg::LD_ADDR;
                        `CMD_RUN: begin
                            run_q   <= 1'b1;
                            state_q <= uart_loader_pkg::LD_SEND;
                        end
                        `CMD_HALT: begin
                            run_q   <= 1'b0;
                            state_q <= uart_loader_pkg::LD_SEND;
                        end
                        default: begin
                            rpl_q   <= {24'd0, `RPL_ERR};
                            state_q <= uart_loader_pkg::LD_SEND;
                        end
                    endcase
                end
            end
            uart_loader_pkg::LD_ADDR: begin
                if (take) begin
                    addr_q     <= {rx_data_i, addr_q[31:8]};
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                    if (byte_cnt_q == 2'd3) begin
                        state_q <= (cmd_q == `CMD_WRITE) ? uart_loader_pkg::LD_DATA
                                                         : uart_loader_pkg::LD_READ;
                    end
                end
            end
            uart_loader_pkg::LD_DATA: begin
                if (take) begin
                    wdata_q    <= {rx_data_i, wdata_q[31:8]};
                    byte_cnt_q <= byte_cnt_q + 2'd1;
                    if (byte_cnt_q == 2'd3) begin
                        state_q <= uart_loader_pkg::LD_WRITE;
                    end
                end
            end
            uart_loader_pkg::LD_WRITE: state_q <= uart_loader_pkg::LD_SEND;
            uart_loader_pkg::LD_READ: begin
                if (byte_cnt_q == 2'd0) begin
                    byte_cnt_q <= 2'd1;             // wait out ram latency
                end else begin
                    rpl_q     <= mem_rdata_i;
                    rpl_cnt_q <= 3'd4;
                    state_q   <= uart_loader_pkg::LD_SEND;
                end
            end
            uart_loader_pkg::LD_SEND: begin
                if (send) begin
                    tx_data_o <= rpl_q[7:0];
                    rpl_q     <= rpl_q >> 8;
                    rpl_cnt_q <= rpl_cnt_q - 3'd1;
                    if (rpl_cnt_q == 3'd1) begin
                        state_q <= uart_loader_pkg::LD_CMD;
                    end
                end
            end
            uart_loader_pkg::LD_FAULT: begin
                rpl_q        <= {24'd0, `RPL_FAULT};
                rpl_cnt_q    <= 3'd1;
                fault_pend_q <= 1'b0;
                state_q      <= uart_loader_pkg::LD_SEND;
            end
            default: state_q <= uart_loader_pkg::LD_CMD;
        endcase
        if (run_q && cpu_fault_i) begin
            run_q        <= 1'b0;                   // hold the cpu
            fault_pend_q <= 1'b1;
        end
    end
end

a_single_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_we_o |-> ($past(take) && cmd_q == `CMD_WRITE) ##1 !mem_we_o);

endmodule

`default_nettype wire

// File: source/ram.sv
// dual port word ram
`timescale 1ns/1ps
`default_nettype none

`include "uart_loader_defines.svh"

module ram(
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  uart_loader_pkg::ram_addr_t a_addr_i,
    input  uart_loader_pkg::word_t     a_wdata_i,
    input  logic                       a_we_i,
    output uart_loader_pkg::word_t     a_rdata_o,

    input  uart_loader_pkg::ram_addr_t b_addr_i,
    output uart_loader_pkg::word_t     b_rdata_o
);

localparam int DEPTH = 1 << `RAM_AW;

uart_loader_pkg::word_t mem [0:DEPTH-1];

always_ff @(posedge clk_i) begin
    if (a_we_i) begin
        mem[a_addr_i] <= a_wdata_i;
    end
end

// port a returns old data on a same cycle write
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        a_rdata_o <= '0;
        b_rdata_o <= '0;
    end else begin
        a_rdata_o <= mem[a_addr_i];
        b_rdata_o <= mem[b_addr_i];             // fetch port
    end
end

endmodule

`default_nettype wire

// File: source/uart_loader_top.sv
// uart loader top level
`timescale 1ns/1ps
`default_nettype none

module uart_loader_top(
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       uart_rx_i,
    output logic                       uart_tx_o,

    input  logic                       cpu_fault_i,
    output logic                       cpu_rst_n_o,

    input  uart_loader_pkg::ram_addr_t cpu_rd_addr_i,
    output uart_loader_pkg::word_t     cpu_rd_data_o
);

uart_loader_pkg::byte_t rx_data;
logic                   rx_done;
logic                   rx_init;

uart_loader_pkg::byte_t tx_data;
logic                   tx_init;
logic                   tx_done;

uart_loader_pkg::ram_addr_t mem_addr;
uart_loader_pkg::word_t     mem_wdata;
uart_loader_pkg::word_t     mem_rdata;
logic                       mem_we;

uart_rx uart_rx(
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),

    .data_i(uart_rx_i),
    .init_i(rx_init),
    .done_o(rx_done),
    .data_o(rx_data)
);

ram_rw ram_rw(
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),

    .rx_data_i(rx_data),
    .rx_done_i(rx_done),
    .rx_init_o(rx_init),

    .tx_data_o(tx_data),
    .tx_init_o(tx_init),
    .tx_done_i(tx_done),

    .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_we_o(mem_we),
    .mem_rdata_i(mem_rdata),

    .cpu_fault_i(cpu_fault_i),
    .cpu_rst_n_o(cpu_rst_n_o)
);

ram ram(
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),

    .a_addr_i(mem_addr),
    .a_wdata_i(mem_wdata),
    .a_we_i(mem_we),
    .a_rdata_o(mem_rdata),

    .b_addr_i(cpu_rd_addr_i),
    .b_rdata_o(cpu_rd_data_o)
);

uart_tx uart_tx(
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),

    .init_i(tx_init),
    .data_i(tx_data),
    .done_o(tx_done),
    .data_o(uart_tx_o)
);

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen(
    output logic clk_o
);

initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;      // 10 ns period
end

endmodule

`default_nettype wire

// File: dv/tb_uart_loader.sv
// uart loader testbench
`timescale 1ns/1ps
`default_nettype none

`include "uart_loader_defines.svh"

module tb_uart_loader;

localparam int FRAME_CYC   = 10 * `BAUD_DIV;
localparam int TIMEOUT_CYC = 125 * FRAME_CYC;   // ~106 frames of traffic plus margin
localparam int NUM_WORDS   = 3;

logic clk;
logic rst_n;
logic uart_rx;
logic uart_tx;
logic cpu_fault;
logic cpu_rst_n;

uart_loader_pkg::ram_addr_t cpu_rd_addr;
uart_loader_pkg::word_t     cpu_rd_data;

logic [31:0] model_mem [0:(1 << `RAM_AW)-1];     // expected ram contents
logic [7:0]  exp_q [$];
logic [7:0]  got_q [$];
logic [31:0] addr_list [0:NUM_WORDS-1];

integer seed   = 32'h264;
int     errors = 0;
int     checks = 0;
int     cycles = 0;
string  cur_test = "reset";

tb_clk_gen clk_gen(
    .clk_o(clk)
);

uart_loader_top DUT(
    .clk_i(clk),
    .rst_n_i(rst_n),

    .uart_rx_i(uart_rx),
    .uart_tx_o(uart_tx),

    .cpu_fault_i(cpu_fault),
    .cpu_rst_n_o(cpu_rst_n),

    .cpu_rd_addr_i(cpu_rd_addr),
    .cpu_rd_data_o(cpu_rd_data)
);

function automatic int model_index(input logic [31:0] addr);
    return int'(addr[`RAM_AW+1:2]);             // upper byte address bits wrap
endfunction

// expected reply bytes for a host command, lsb first in rpl
function automatic int expected_reply(input logic [7:0] cmd, input logic [31:0] addr,
                                      output logic [31:0] rpl);
    case (cmd)
        `CMD_WRITE, `CMD_RUN, `CMD_HALT: begin
            rpl = {24'd0, cmd};                 // echo
            return 1;
        end
        `CMD_READ: begin
            rpl = model_mem[model_index(addr)];
            return 4;
        end
        default: begin
            rpl = {24'd0, `RPL_ERR};
            return 1;
        end
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
    end
endtask

task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(posedge clk);
        #1 uart_rx = frame[i];
        repeat (`BAUD_DIV - 1) @(posedge clk);
    end
endtask

task automatic receive_byte(output logic [7:0] b);
    int i;
    @(negedge clk);
    while (uart_tx !== 1'b0) begin
        @(negedge clk);
    end
    repeat (`BAUD_DIV / 2) @(negedge clk);      // middle of start bit
    for (i = 0; i < 8; i++) begin
        repeat (`BAUD_DIV) @(negedge clk);
        b[i] = uart_tx;
    end
    repeat (`BAUD_DIV) @(negedge clk);
    if (uart_tx !== 1'b1) begin
        errors++;
        $display("stop bit missing on the serial output during %s", cur_test);
    end
endtask

task automatic run_cmd(input logic [7:0] cmd, input logic [31:0] addr,
                       input logic [31:0] data);
    logic [31:0] rpl;
    int n;
    int i;
    n = expected_reply(cmd, addr, rpl);
    for (i = 0; i < n; i++) begin
        exp_q.push_back(rpl[8*i +: 8]);
    end
    send_byte(cmd);
    if (cmd == `CMD_WRITE || cmd == `CMD_READ) begin
        for (i = 0; i < 4; i++) begin
            send_byte(addr[8*i +: 8]);
        end
    end
    if (cmd == `CMD_WRITE) begin
        for (i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8]);
        end
        model_mem[model_index(addr)] = data;
    end
    while (exp_q.size() != 0) begin
        @(posedge clk);
    end
endtask

task automatic check_fetch(input logic [31:0] addr);
    @(posedge clk);
    #1 cpu_rd_addr = uart_loader_pkg::ram_addr_t'(model_index(addr));
    @(posedge clk);
    @(negedge clk);
    check_value("fetch port", model_mem[model_index(addr)], cpu_rd_data);
endtask

task automatic check_cpu_rst(input string name, input logic exp);
    @(negedge clk);
    check_value(name, {31'd0, exp}, {31'd0, cpu_rst_n});
endtask

// serial monitor
initial begin
    logic [7:0] b;
    forever begin
        receive_byte(b);
        got_q.push_back(b);
    end
end

// reply comparison
initial begin
    forever begin
        @(negedge clk);
        while (exp_q.size() != 0 && got_q.size() != 0) begin
            check_value(cur_test, {24'd0, exp_q.pop_front()}, {24'd0, got_q.pop_front()});
        end
    end
end

initial begin
    while (cycles < TIMEOUT_CYC) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout, run still busy after %0d cycles in %s", cycles, cur_test);
    $display("*** TEST FAILED ***");
    $finish;
end

initial begin
    logic [31:0] base;
    int i;
    rst_n       = 1'b0;
    uart_rx     = 1'b1;
    cpu_fault   = 1'b0;
    cpu_rd_addr = '0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    check_cpu_rst("cpu held after reset", 1'b0);

    cur_test = "write read";
    for (i = 0; i < NUM_WORDS; i++) begin
        addr_list[i] = $random(seed) & ~32'h3;
        run_cmd(`CMD_WRITE, addr_list[i], $random(seed));
    end
    for (i = 0; i < NUM_WORDS; i++) begin
        run_cmd(`CMD_READ, addr_list[i], 32'd0);
    end

    cur_test = "alias";
    base = 32'h0000_0040;
    run_cmd(`CMD_WRITE, base, $random(seed));
    run_cmd(`CMD_WRITE, base + 4 * (1 << `RAM_AW), $random(seed));   // same word
    run_cmd(`CMD_READ, base, 32'd0);

    cur_test = "fetch";
    for (i = 0; i < NUM_WORDS; i++) begin
        check_fetch(addr_list[i]);
    end
    check_fetch(base);

    cur_test = "run halt";
    run_cmd(`CMD_RUN, 32'd0, 32'd0);
    check_cpu_rst("cpu released by run", 1'b1);
    run_cmd(`CMD_HALT, 32'd0, 32'd0);
    check_cpu_rst("cpu held by halt", 1'b0);

    cur_test = "error resync";
    run_cmd(8'h5A, 32'd0, 32'd0);
    run_cmd(`CMD_READ, addr_list[0], 32'd0);

    cur_test = "fault";
    run_cmd(`CMD_RUN, 32'd0, 32'd0);
    check_cpu_rst("cpu running before fault", 1'b1);
    exp_q.push_back(`RPL_FAULT);
    @(posedge clk);
    #1 cpu_fault = 1'b1;
    repeat (4) @(posedge clk);
    #1 cpu_fault = 1'b0;
    while (exp_q.size() != 0) begin
        @(posedge clk);
    end
    check_cpu_rst("cpu held after fault", 1'b0);
    repeat (2 * FRAME_CYC) @(posedge clk);          // room for a repeated report
    check_value("extra reply bytes", 32'd0, got_q.size());

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: uart_loader.f
+incdir+source
source/uart_loader_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/ram_rw.sv
source/ram.sv
source/uart_loader_top.sv
dv/tb_clk_gen.sv
dv/tb_uart_loader.sv
